//--- otp_fault_merge.sv
// Read response merge applying zeroization and fault injection to fuse read data
module otp_fault_merge (
  input  logic                  rd_valid_i,
  input  svc_pkg::otp_word_t    rd_data_i,
  input  logic                  rd_locked_i,
  input  logic                  zeroize_i,
  input  svc_pkg::fault_mode_e  fault_mode_i,
  output logic                  rsp_valid_o,
  output svc_pkg::otp_word_t    rsp_data_o
);

  svc_pkg::otp_word_t flip_mask;

  // The response leaves in the same cycle as the array word
  assign rsp_valid_o = rd_valid_i;

  // ----------------------------------------------------------
  // Fault mask
  // ----------------------------------------------------------
  // Only the first word of a locked partition is ever disturbed
  always_comb begin
    flip_mask = '0;
    if (rd_locked_i) begin
      case (fault_mode_i)
        svc_pkg::FAULT_CORR:   flip_mask = svc_pkg::otp_word_t'(1);
        svc_pkg::FAULT_UNCORR: flip_mask = '1;
        default:               flip_mask = '0;
      endcase
    end
  end

  // ----------------------------------------------------------
  // Response data
  // ----------------------------------------------------------
  // Zeroization wins over any armed fault
  always_comb begin
    if (zeroize_i) begin
      rsp_data_o = '0;
    end else begin
      rsp_data_o = rd_data_i ^ flip_mask;
    end
  end

endmodule

//--- otp_fuse_array.sv
// Fuse word storage with programming port, partition lock bits and registered read port
module otp_fuse_array (
  input  logic                clk,
  input  logic                cptra_rst_b,
  input  logic                sub_rst_b_i,
  input  logic                prog_valid_i,
  input  svc_pkg::otp_addr_t  prog_addr_i,
  input  svc_pkg::otp_word_t  prog_data_i,
  input  logic                rd_valid_i,
  input  svc_pkg::otp_addr_t  rd_addr_i,
  output logic                rd_ready_o,
  output logic                rd_valid_o,
  output svc_pkg::otp_addr_t  rd_addr_o,
  output svc_pkg::otp_word_t  rd_data_o,
  output logic                rd_locked_o
);

  localparam int NUM_WORDS = 2 ** svc_pkg::OTP_ADDR_W;

  svc_pkg::otp_word_t           mem [NUM_WORDS];
  logic [NUM_WORDS-1:0]         written_q;
  logic [svc_pkg::NUM_PARTS-1:0] lock_q;
  logic                         req_vld_q;
  svc_pkg::otp_addr_t           req_addr_q;
  logic                         req_take;

  // Lock bit of the partition starting at addr, zero for any other word
  function automatic logic offset_locked(input svc_pkg::otp_addr_t addr,
                                         input logic [svc_pkg::NUM_PARTS-1:0] locks);
    logic hit;
    hit = 1'b0;
    for (int p = 0; p < svc_pkg::NUM_PARTS; p++) begin
      if (addr == svc_pkg::PART_OFFSET[p]) begin
        hit = locks[p];
      end
    end
    return hit;
  endfunction

  // Reads stall while the sub-block is held in reset
  assign rd_ready_o = sub_rst_b_i;
  assign req_take   = rd_valid_i && rd_ready_o;

  // ----------------------------------------------------------
  // Programming port
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (prog_valid_i) begin
      mem[prog_addr_i] <= prog_data_i;
    end
  end

  // Blank fuses read as zero until they are programmed
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      written_q <= '0;
      lock_q    <= '0;
    end else if (prog_valid_i) begin
      written_q[prog_addr_i] <= 1'b1;
      for (int p = 0; p < svc_pkg::NUM_PARTS; p++) begin
        if (prog_addr_i == svc_pkg::PART_DIGEST[p]) begin
          lock_q[p] <= |prog_data_i;
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Read pipeline
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      req_vld_q   <= 1'b0;
      rd_valid_o  <= 1'b0;
      rd_locked_o <= 1'b0;
    end else begin
      req_vld_q   <= req_take;
      rd_valid_o  <= req_vld_q;
      rd_locked_o <= req_vld_q && offset_locked(req_addr_q, lock_q);
    end
  end

  // A write at the same edge as the array read is not seen by that read
  always_ff @(posedge clk) begin
    if (req_take) begin
      req_addr_q <= rd_addr_i;
    end
    if (req_vld_q) begin
      rd_addr_o <= req_addr_q;
      rd_data_o <= written_q[req_addr_q] ? mem[req_addr_q] : '0;
    end
  end

endmodule

//--- otp_svc_props.sv
// Concurrent assertions on FIFO overflow, reset pulse length and read response timing
module otp_svc_props #(
  parameter int CMD_DEPTH = 4,
  parameter int RD_DEPTH  = 4
) (
  input logic clk,
  input logic cptra_rst_b,
  input logic cmd_valid_i,
  input logic cmd_pop_valid,
  input logic cmd_pop_ready,
  input logic rd_valid_i,
  input logic rd_pop_valid,
  input logic rd_pop_ready,
  input logic sub_rst_b_o,
  input logic rd_rsp_valid_o
);
  timeunit 1ns;
  timeprecision 100ps;

  int   cmd_cnt_q;
  int   rd_cnt_q;
  logic cmd_pop;
  logic rd_pop;

  assign cmd_pop = cmd_pop_valid && cmd_pop_ready;
  assign rd_pop  = rd_pop_valid && rd_pop_ready;

  // Shadow occupancy of both FIFOs is built from their push and pop handshakes
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      cmd_cnt_q <= 0;
      rd_cnt_q  <= 0;
    end else begin
      cmd_cnt_q <= cmd_cnt_q + int'(cmd_valid_i) - int'(cmd_pop);
      rd_cnt_q  <= rd_cnt_q + int'(rd_valid_i) - int'(rd_pop);
    end
  end

  // ----------------------------------------------------------
  // Properties
  // ----------------------------------------------------------
  cmd_no_overflow: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    cmd_valid_i |-> (cmd_cnt_q < CMD_DEPTH))
    else $error("Push into a full command FIFO");

  rd_no_overflow: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    rd_valid_i |-> (rd_cnt_q < RD_DEPTH))
    else $error("Push into a full read FIFO");

  sub_rst_pulse_len: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    $fell(sub_rst_b_o) |-> (!sub_rst_b_o) [*svc_pkg::RST_PULSE_CYCLES] ##1 sub_rst_b_o)
    else $error("Sub-block reset pulse has the wrong length");

  rsp_after_pop: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    rd_rsp_valid_o |-> $past(rd_pop, 2))
    else $error("Read response without a read pop two edges before");

endmodule

bind otp_svc_top otp_svc_props #(
  .CMD_DEPTH (CMD_DEPTH),
  .RD_DEPTH  (RD_DEPTH)
) u_props (
  .clk            (clk),
  .cptra_rst_b    (cptra_rst_b),
  .cmd_valid_i    (cmd_valid_i),
  .cmd_pop_valid  (cmd_pop_valid),
  .cmd_pop_ready  (cmd_pop_ready),
  .rd_valid_i     (rd_valid_i),
  .rd_pop_valid   (rd_pop_valid),
  .rd_pop_ready   (rd_pop_ready),
  .sub_rst_b_o    (sub_rst_b_o),
  .rd_rsp_valid_o (rd_rsp_valid_o)
);

//--- otp_svc_top.sv
// Fuse test-service top level with command and read FIFOs, decoder, array and merge
module otp_svc_top #(
  parameter int CMD_DEPTH = 4,
  parameter int RD_DEPTH  = 4
) (
  input  logic                  clk,
  input  logic                  cptra_rst_b,
  input  logic                  cmd_valid_i,
  input  svc_pkg::svc_cmd_t     cmd_i,
  output logic                  cmd_credit_o,
  input  logic                  rd_valid_i,
  input  svc_pkg::otp_addr_t    rd_addr_i,
  output logic                  rd_credit_o,
  input  logic                  prog_valid_i,
  input  svc_pkg::otp_addr_t    prog_addr_i,
  input  svc_pkg::otp_word_t    prog_data_i,
  output logic                  rd_rsp_valid_o,
  output svc_pkg::otp_word_t    rd_rsp_data_o,
  output logic                  sub_rst_b_o,
  output logic [1:0]            clk_sel_o,
  output logic                  zeroize_o,
  output svc_pkg::fault_mode_e  fault_mode_o
);

  // Command FIFO to decoder
  logic               cmd_pop_valid;
  logic               cmd_pop_ready;
  svc_pkg::svc_cmd_t  cmd_pop_data;

  // Read FIFO to array
  logic               rd_pop_valid;
  logic               rd_pop_ready;
  svc_pkg::otp_addr_t rd_pop_data;

  // Array to merge
  logic               rd_valid_q;
  svc_pkg::otp_word_t rd_data;
  logic               rd_locked_q;

  // ----------------------------------------------------------
  // Command path
  // ----------------------------------------------------------
  svc_credit_fifo #(
    .payload_t (svc_pkg::svc_cmd_t),
    .DEPTH     (CMD_DEPTH)
  ) u_cmd_fifo (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .push_i      (cmd_valid_i),
    .push_data_i (cmd_i),
    .pop_ready_i (cmd_pop_ready),
    .pop_valid_o (cmd_pop_valid),
    .pop_data_o  (cmd_pop_data),
    .credit_o    (cmd_credit_o)
  );

  svc_cmd_decoder u_decoder (
    .clk          (clk),
    .cptra_rst_b  (cptra_rst_b),
    .cmd_valid_i  (cmd_pop_valid),
    .cmd_i        (cmd_pop_data),
    .cmd_ready_o  (cmd_pop_ready),
    .sub_rst_b_o  (sub_rst_b_o),
    .clk_sel_o    (clk_sel_o),
    .zeroize_o    (zeroize_o),
    .fault_mode_o (fault_mode_o)
  );

  // ----------------------------------------------------------
  // Read path
  // ----------------------------------------------------------
  svc_credit_fifo #(
    .payload_t (svc_pkg::otp_addr_t),
    .DEPTH     (RD_DEPTH)
  ) u_rd_fifo (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .push_i      (rd_valid_i),
    .push_data_i (rd_addr_i),
    .pop_ready_i (rd_pop_ready),
    .pop_valid_o (rd_pop_valid),
    .pop_data_o  (rd_pop_data),
    .credit_o    (rd_credit_o)
  );

  // The decoder's reset pulse holds the read FIFO through the array's ready
  otp_fuse_array u_array (
    .clk          (clk),
    .cptra_rst_b  (cptra_rst_b),
    .sub_rst_b_i  (sub_rst_b_o),
    .prog_valid_i (prog_valid_i),
    .prog_addr_i  (prog_addr_i),
    .prog_data_i  (prog_data_i),
    .rd_valid_i   (rd_pop_valid),
    .rd_addr_i    (rd_pop_data),
    .rd_ready_o   (rd_pop_ready),
    .rd_valid_o   (rd_valid_q),
    .rd_addr_o    (),
    .rd_data_o    (rd_data),
    .rd_locked_o  (rd_locked_q)
  );

  otp_fault_merge u_merge (
    .rd_valid_i   (rd_valid_q),
    .rd_data_i    (rd_data),
    .rd_locked_i  (rd_locked_q),
    .zeroize_i    (zeroize_o),
    .fault_mode_i (fault_mode_o),
    .rsp_valid_o  (rd_rsp_valid_o),
    .rsp_data_o   (rd_rsp_data_o)
  );

endmodule

//--- svc_cmd_decoder.sv
// Service command decoder for reset pulse, clock select, zeroization and fault mode
module svc_cmd_decoder (
  input  logic                  clk,
  input  logic                  cptra_rst_b,
  input  logic                  cmd_valid_i,
  input  svc_pkg::svc_cmd_t     cmd_i,
  output logic                  cmd_ready_o,
  output logic                  sub_rst_b_o,
  output logic [1:0]            clk_sel_o,
  output logic                  zeroize_o,
  output svc_pkg::fault_mode_e  fault_mode_o
);

  logic              cmd_take;
  logic              cmd_vld_q;
  svc_pkg::svc_cmd_t cmd_q;
  logic [3:0]        pulse_cnt_q;
  logic              pulse_start;

  // Commands never stall, every popped entry is decoded
  assign cmd_ready_o = 1'b1;
  assign cmd_take    = cmd_valid_i && cmd_ready_o;

  // ----------------------------------------------------------
  // Capture stage
  // ----------------------------------------------------------
  // The popped command is held for one cycle before it takes effect
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      cmd_vld_q <= 1'b0;
    end else begin
      cmd_vld_q <= cmd_take;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_take) begin
      cmd_q <= cmd_i;
    end
  end

  // ----------------------------------------------------------
  // Lasting control state
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      clk_sel_o    <= 2'd0;
      zeroize_o    <= 1'b0;
      fault_mode_o <= svc_pkg::FAULT_NONE;
    end else if (cmd_vld_q) begin
      case (cmd_q)
        svc_pkg::CMD_CLK_500:     clk_sel_o <= 2'd0;
        svc_pkg::CMD_CLK_160:     clk_sel_o <= 2'd1;
        svc_pkg::CMD_CLK_400:     clk_sel_o <= 2'd2;
        svc_pkg::CMD_CLK_1000:    clk_sel_o <= 2'd3;
        svc_pkg::CMD_ZEROIZE_ON:  zeroize_o <= 1'b1;
        svc_pkg::CMD_ZEROIZE_OFF: zeroize_o <= 1'b0;
        // A fault is armed only from the idle mode, a second one waits for a clear
        svc_pkg::CMD_FAULT_CORR: begin
          if (fault_mode_o == svc_pkg::FAULT_NONE) begin
            fault_mode_o <= svc_pkg::FAULT_CORR;
          end
        end
        svc_pkg::CMD_FAULT_UNCORR: begin
          if (fault_mode_o == svc_pkg::FAULT_NONE) begin
            fault_mode_o <= svc_pkg::FAULT_UNCORR;
          end
        end
        svc_pkg::CMD_FAULT_CLEAR: fault_mode_o <= svc_pkg::FAULT_NONE;
        default: begin
          // Reset pulse is handled below, anything else is not a command
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // Sub-block reset pulse
  // ----------------------------------------------------------
  // A request while the pulse is running is dropped
  assign pulse_start = cmd_vld_q && (cmd_q == svc_pkg::CMD_RESET_PULSE) && sub_rst_b_o;

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      sub_rst_b_o <= 1'b1;
      pulse_cnt_q <= 4'd0;
    end else if (pulse_start) begin
      sub_rst_b_o <= 1'b0;
      pulse_cnt_q <= 4'd0;
    end else if (!sub_rst_b_o) begin
      // Low in the cycles where the count runs from 0 to RST_PULSE_CYCLES-1
      if (pulse_cnt_q == 4'(svc_pkg::RST_PULSE_CYCLES - 1)) begin
        sub_rst_b_o <= 1'b1;
        pulse_cnt_q <= 4'd0;
      end else begin
        pulse_cnt_q <= pulse_cnt_q + 4'd1;
      end
    end
  end

endmodule

//--- svc_credit_fifo.sv
// Credit-returning receive FIFO with a payload type parameter
module svc_credit_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     cptra_rst_b,
  input  logic     push_i,
  input  payload_t push_data_i,
  input  logic     pop_ready_i,
  output logic     pop_valid_o,
  output payload_t pop_data_o,
  output logic     credit_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             push_ok;
  logic             pop_fire;

  // Pointers wrap at DEPTH so that any depth works, not only powers of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign full        = (count_q == CNT_W'(DEPTH));
  assign push_ok     = push_i && !full;
  assign pop_valid_o = (count_q != '0);
  assign pop_data_o  = mem[rd_ptr_q];
  assign pop_fire    = pop_valid_o && pop_ready_i;

  // Entry storage
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  // ----------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_fire) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q <= count_q + CNT_W'(push_ok) - CNT_W'(pop_fire);
    end
  end

  // One credit goes back to the sender for every entry that leaves
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      credit_o <= 1'b0;
    end else begin
      credit_o <= pop_fire;
    end
  end

endmodule

//--- svc_pkg.sv
// Service package with command codes, fuse widths, fault mode type and partition table
package svc_pkg;

  // ----------------------------------------------------------
  // Service command codes
  // ----------------------------------------------------------
  typedef logic [7:0] svc_cmd_t;

  localparam svc_cmd_t CMD_RESET_PULSE  = 8'h10;
  localparam svc_cmd_t CMD_ZEROIZE_ON   = 8'h11;
  localparam svc_cmd_t CMD_ZEROIZE_OFF  = 8'h12;
  localparam svc_cmd_t CMD_CLK_500      = 8'h20;
  localparam svc_cmd_t CMD_CLK_160      = 8'h21;
  localparam svc_cmd_t CMD_CLK_400      = 8'h22;
  localparam svc_cmd_t CMD_CLK_1000     = 8'h23;
  localparam svc_cmd_t CMD_FAULT_CORR   = 8'h30;
  localparam svc_cmd_t CMD_FAULT_UNCORR = 8'h31;
  localparam svc_cmd_t CMD_FAULT_CLEAR  = 8'h32;

  // Fault injection mode applied to the first word of locked partitions
  typedef enum logic [1:0] {
    FAULT_NONE   = 2'd0,
    FAULT_CORR   = 2'd1,
    FAULT_UNCORR = 2'd2
  } fault_mode_e;

  // ----------------------------------------------------------
  // Fuse array geometry
  // ----------------------------------------------------------
  localparam int OTP_WORD_W = 16;
  // Eleven bits so that the highest digest word (5D4 hex) is addressable
  localparam int OTP_ADDR_W = 11;

  typedef logic [OTP_WORD_W-1:0] otp_word_t;
  typedef logic [OTP_ADDR_W-1:0] otp_addr_t;

  localparam int NUM_PARTS = 8;

  // First word of each partition, which is the word that faults target
  localparam otp_addr_t PART_OFFSET [NUM_PARTS] = '{
    11'h000, 11'h024, 11'h048, 11'h050, 11'h058, 11'h060, 11'h260, 11'h4D4
  };

  // A nonzero value in the digest word locks its partition
  localparam otp_addr_t PART_DIGEST [NUM_PARTS] = '{
    11'h020, 11'h044, 11'h04C, 11'h054, 11'h05C, 11'h064, 11'h2B8, 11'h5D4
  };

  // Length of the sub-block reset pulse in clock cycles
  localparam int RST_PULSE_CYCLES = 11;

endpackage

//--- tb_otp_svc.sv
// Random-stimulus testbench for the fuse test-service top level with reference model and checks
module tb_otp_svc;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CMD_DEPTH = 4;
  localparam int RD_DEPTH  = 4;
  localparam int WAIT_MAX  = 200;

  logic                 clk;
  logic                 cptra_rst_b;
  logic                 cmd_valid;
  svc_pkg::svc_cmd_t    cmd;
  logic                 cmd_credit;
  logic                 rd_valid;
  svc_pkg::otp_addr_t   rd_addr;
  logic                 rd_credit;
  logic                 prog_valid;
  svc_pkg::otp_addr_t   prog_addr;
  svc_pkg::otp_word_t   prog_data;
  logic                 rsp_valid;
  svc_pkg::otp_word_t   rsp_data;
  logic                 sub_rst_b;
  logic [1:0]           clk_sel;
  logic                 zeroize;
  svc_pkg::fault_mode_e fault_mode;

  // Reference model of the array, its locks and the decoder state
  svc_pkg::otp_word_t            model_mem [2**svc_pkg::OTP_ADDR_W];
  logic [svc_pkg::NUM_PARTS-1:0] model_lock;
  logic [1:0]                    m_clk_sel;
  logic                          m_zeroize;
  svc_pkg::fault_mode_e          m_fault;
  logic                          m_sub_rst_b;
  svc_pkg::otp_addr_t            exp_q [$];

  int seed = 3;
  int cmd_credits = CMD_DEPTH;
  int rd_credits = RD_DEPTH;
  int cmd_sent;
  int cmd_returned;
  int rd_sent;
  int rd_returned;
  int low_cycles;
  int value_errs;
  int other_errs;

  otp_svc_top #(
    .CMD_DEPTH (CMD_DEPTH),
    .RD_DEPTH  (RD_DEPTH)
  ) u_dut (
    .clk            (clk),
    .cptra_rst_b    (cptra_rst_b),
    .cmd_valid_i    (cmd_valid),
    .cmd_i          (cmd),
    .cmd_credit_o   (cmd_credit),
    .rd_valid_i     (rd_valid),
    .rd_addr_i      (rd_addr),
    .rd_credit_o    (rd_credit),
    .prog_valid_i   (prog_valid),
    .prog_addr_i    (prog_addr),
    .prog_data_i    (prog_data),
    .rd_rsp_valid_o (rsp_valid),
    .rd_rsp_data_o  (rsp_data),
    .sub_rst_b_o    (sub_rst_b),
    .clk_sel_o      (clk_sel),
    .zeroize_o      (zeroize),
    .fault_mode_o   (fault_mode)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ----------------------------------------------------------
  // Model helpers
  // ----------------------------------------------------------
  function automatic int unsigned rand_below(input int unsigned n);
    int unsigned r;
    r = $unsigned($random(seed));
    return r % n;
  endfunction

  // Reads lean on the partition offset and digest words
  function automatic svc_pkg::otp_addr_t pick_addr();
    int unsigned kind;
    int unsigned p;
    kind = rand_below(4);
    p = rand_below(svc_pkg::NUM_PARTS);
    case (kind)
      0: return svc_pkg::PART_OFFSET[p];
      1: return svc_pkg::PART_DIGEST[p];
      2: return svc_pkg::PART_OFFSET[p] + 1'b1;
      default: return svc_pkg::otp_addr_t'(rand_below(2**svc_pkg::OTP_ADDR_W));
    endcase
  endfunction

  // Zeroization first, then a fault on the first word of a locked partition
  function automatic svc_pkg::otp_word_t expected_word(input svc_pkg::otp_addr_t addr);
    logic               locked;
    svc_pkg::otp_word_t w;
    locked = 1'b0;
    for (int p = 0; p < svc_pkg::NUM_PARTS; p++) begin
      if (addr == svc_pkg::PART_OFFSET[p] && model_lock[p])
        locked = 1'b1;
    end
    w = model_mem[addr];
    if (m_zeroize)
      w = '0;
    else if (locked && m_fault == svc_pkg::FAULT_CORR)
      w[0] = ~w[0];
    else if (locked && m_fault == svc_pkg::FAULT_UNCORR)
      w = ~w;
    return w;
  endfunction

  task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] got);
    assert (got === exp)
    else begin
      $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, got);
      value_errs++;
    end
  endtask

  task automatic end_on_timeout(input string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    other_errs++;
    $display("Value errors: %0d, other errors: %0d", value_errs, other_errs);
    $display("Done: errors found");
    $finish;
  endtask

  task automatic check_ctrl();
    check_val("clk_sel_o", 16'(m_clk_sel), 16'(clk_sel));
    check_val("zeroize_o", 16'(m_zeroize), 16'(zeroize));
    check_val("fault_mode_o", 16'(m_fault), 16'(fault_mode));
    check_val("sub_rst_b_o", 16'(m_sub_rst_b), 16'(sub_rst_b));
  endtask

  // ----------------------------------------------------------
  // Drivers, entered 1 ns after a rising edge
  // ----------------------------------------------------------
  task automatic send_cmd(input svc_pkg::svc_cmd_t code);
    int waited;
    waited = 0;
    while (cmd_credits == 0) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > WAIT_MAX)
        end_on_timeout("a command credit");
    end
    cmd_valid = 1'b1;
    cmd = code;
    cmd_credits--;
    cmd_sent++;
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
  endtask

  // The decoder outputs change after the second edge following the push
  task automatic issue_cmd(input svc_pkg::svc_cmd_t code);
    send_cmd(code);
    repeat (2) @(posedge clk);
    #1;
    case (code)
      svc_pkg::CMD_RESET_PULSE:  m_sub_rst_b = 1'b0;
      svc_pkg::CMD_ZEROIZE_ON:   m_zeroize = 1'b1;
      svc_pkg::CMD_ZEROIZE_OFF:  m_zeroize = 1'b0;
      svc_pkg::CMD_CLK_500:      m_clk_sel = 2'd0;
      svc_pkg::CMD_CLK_160:      m_clk_sel = 2'd1;
      svc_pkg::CMD_CLK_400:      m_clk_sel = 2'd2;
      svc_pkg::CMD_CLK_1000:     m_clk_sel = 2'd3;
      svc_pkg::CMD_FAULT_CORR:   if (m_fault == svc_pkg::FAULT_NONE) m_fault = svc_pkg::FAULT_CORR;
      svc_pkg::CMD_FAULT_UNCORR: if (m_fault == svc_pkg::FAULT_NONE) m_fault = svc_pkg::FAULT_UNCORR;
      svc_pkg::CMD_FAULT_CLEAR:  m_fault = svc_pkg::FAULT_NONE;
      default: ;
    endcase
    check_ctrl();
  endtask

  task automatic send_read(input svc_pkg::otp_addr_t addr);
    int waited;
    waited = 0;
    while (rd_credits == 0) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > WAIT_MAX)
        end_on_timeout("a read credit");
    end
    rd_valid = 1'b1;
    rd_addr = addr;
    rd_credits--;
    rd_sent++;
    exp_q.push_back(addr);
    @(posedge clk);
    #1;
    rd_valid = 1'b0;
  endtask

  task automatic program_word(input svc_pkg::otp_addr_t addr, input svc_pkg::otp_word_t data);
    prog_valid = 1'b1;
    prog_addr = addr;
    prog_data = data;
    model_mem[addr] = data;
    for (int p = 0; p < svc_pkg::NUM_PARTS; p++) begin
      if (addr == svc_pkg::PART_DIGEST[p])
        model_lock[p] = |data;
    end
    @(posedge clk);
    #1;
    prog_valid = 1'b0;
  endtask

  task automatic drain_reads();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > WAIT_MAX)
        end_on_timeout("outstanding read responses");
    end
  endtask

  task automatic read_offsets_and_random(input int n);
    for (int p = 0; p < svc_pkg::NUM_PARTS; p++)
      send_read(svc_pkg::PART_OFFSET[p]);
    repeat (n) send_read(pick_addr());
    drain_reads();
  endtask

  // ----------------------------------------------------------
  // Monitor, sampling in the middle of the cycle
  // ----------------------------------------------------------
  always @(negedge clk) begin
    svc_pkg::otp_addr_t addr;
    if (cptra_rst_b) begin
      if (cmd_credit) begin
        cmd_credits++;
        cmd_returned++;
      end
      if (rd_credit) begin
        rd_credits++;
        rd_returned++;
      end
      assert (cmd_credits <= CMD_DEPTH && rd_credits <= RD_DEPTH)
      else begin
        $display("More credits returned than the FIFO depth at %0t", $time);
        other_errs++;
      end
      assert (sub_rst_b || !(rd_credit || rsp_valid))
      else begin
        $display("Read credit or response during the sub-block reset at %0t", $time);
        other_errs++;
      end
      if (!sub_rst_b) begin
        low_cycles++;
      end else if (low_cycles != 0) begin
        check_val("sub_rst_b_o low cycles", svc_pkg::RST_PULSE_CYCLES, low_cycles);
        low_cycles = 0;
      end
      if (rsp_valid) begin
        if (exp_q.size() == 0) begin
          $display("Read response with no read outstanding at %0t", $time);
          other_errs++;
        end else begin
          addr = exp_q.pop_front();
          check_val("rd_rsp_data_o", expected_word(addr), rsp_data);
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    cptra_rst_b = 1'b0;
    cmd_valid = 1'b0;
    cmd = '0;
    rd_valid = 1'b0;
    rd_addr = '0;
    prog_valid = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    for (int a = 0; a < 2**svc_pkg::OTP_ADDR_W; a++)
      model_mem[a] = '0;
    model_lock = '0;
    m_clk_sel = 2'd0;
    m_zeroize = 1'b0;
    m_fault = svc_pkg::FAULT_NONE;
    m_sub_rst_b = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    cptra_rst_b = 1'b1;
    check_ctrl();
    check_val("rd_rsp_valid_o", 16'h0, 16'(rsp_valid));

    // Partition 0 always locks and partition 1 never does, the rest at random
    for (int p = 0; p < svc_pkg::NUM_PARTS; p++) begin
      program_word(svc_pkg::PART_OFFSET[p], svc_pkg::otp_word_t'($random(seed)));
      program_word(svc_pkg::PART_OFFSET[p] + 1'b1, svc_pkg::otp_word_t'($random(seed)));
      if (p == 0 || (p > 1 && rand_below(2) == 1))
        program_word(svc_pkg::PART_DIGEST[p], svc_pkg::otp_word_t'($random(seed)) | 16'h1);
      else
        program_word(svc_pkg::PART_DIGEST[p], '0);
    end
    repeat (12) program_word(pick_addr(), svc_pkg::otp_word_t'($random(seed)));
    read_offsets_and_random(24);

    // Faults, with a second arm ignored until the clear
    issue_cmd(svc_pkg::CMD_FAULT_CORR);
    read_offsets_and_random(8);
    issue_cmd(svc_pkg::CMD_FAULT_UNCORR);
    read_offsets_and_random(4);
    issue_cmd(svc_pkg::CMD_FAULT_CLEAR);
    issue_cmd(svc_pkg::CMD_FAULT_UNCORR);
    read_offsets_and_random(8);

    // Zeroization overrides the armed fault
    issue_cmd(svc_pkg::CMD_ZEROIZE_ON);
    read_offsets_and_random(8);
    issue_cmd(svc_pkg::CMD_ZEROIZE_OFF);
    read_offsets_and_random(4);

    // Clock select, then codes from 40 to FF hex which are not commands
    issue_cmd(svc_pkg::CMD_CLK_160);
    issue_cmd(svc_pkg::CMD_CLK_1000);
    issue_cmd(svc_pkg::CMD_CLK_400);
    issue_cmd(svc_pkg::CMD_CLK_500);
    repeat (6) issue_cmd(svc_pkg::svc_cmd_t'(8'h40 + rand_below(8'hC0)));

    // Reads queued during the reset pulse complete after it
    issue_cmd(svc_pkg::CMD_RESET_PULSE);
    repeat (6) send_read(pick_addr());
    for (int w = 0; !sub_rst_b; w++) begin
      if (w > WAIT_MAX)
        end_on_timeout("the end of the reset pulse");
      @(posedge clk);
      #1;
    end
    m_sub_rst_b = 1'b1;
    drain_reads();
    check_ctrl();

    // Mixed run of reads, clock commands and unknown codes
    repeat (60) begin
      case (rand_below(4))
        0: issue_cmd(svc_pkg::CMD_CLK_500 + svc_pkg::svc_cmd_t'(rand_below(4)));
        1: issue_cmd(svc_pkg::svc_cmd_t'(8'h40 + rand_below(8'hC0)));
        default: send_read(pick_addr());
      endcase
    end
    drain_reads();
    repeat (3) @(posedge clk);
    #1;
    assert (cmd_credits == CMD_DEPTH && cmd_returned == cmd_sent)
    else begin
      $display("Command credits do not match: sent %0d, returned %0d", cmd_sent, cmd_returned);
      other_errs++;
    end
    assert (rd_credits == RD_DEPTH && rd_returned == rd_sent)
    else begin
      $display("Read credits do not match: sent %0d, returned %0d", rd_sent, rd_returned);
      other_errs++;
    end

    $display("Value errors: %0d, other errors: %0d", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

//--- vlog.f
svc_pkg.sv
svc_credit_fifo.sv
svc_cmd_decoder.sv
otp_fuse_array.sv
otp_fault_merge.sv
otp_svc_top.sv
otp_svc_props.sv
tb_otp_svc.sv
